// File: Bender.yml
package:
  name: axi_write_xbar

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/axi_pkg.sv
      - hdl/xbar_pkg.sv
      - hdl/axi_w_if.sv
      - hdl/aw_decoder.sv
      - hdl/w_router.sv
      - hdl/b_mux.sv
      - hdl/axi_write_xbar.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/tb_axi_write_xbar.sv

// File: dv/tb_axi_write_xbar.sv
`include "axi_params.svh"

module tb_axi_write_xbar;
  timeunit 1ns;
  timeprecision 1ps;
  import axi_pkg::*;

  localparam int NS       = `AXI_NUM_SLAVES;
  localparam int NUM_ROWS = 8;
  localparam int TIMEOUT  = 200;

  typedef struct packed {
    addr_t      addr;
    logic [7:0] beats;
    data_t      data;
    strb_t      strb;
    logic [1:0] slave;
    resp_t      resp;
  } row_t;

  // Address, beat count, first data word, strobe, expected slave and response
  row_t rows [NUM_ROWS] = '{
    '{32'h0000_0040, 8'd4, 32'h1000_0000, 4'hf, 2'd0, RESP_OKAY},
    '{32'h0001_0100, 8'd3, 32'h2000_0010, 4'h3, 2'd1, RESP_EXOKAY},
    '{32'h0002_0000, 8'd2, 32'h3000_0000, 4'hc, 2'd2, RESP_SLVERR},
    '{32'hffff_fffc, 8'd1, 32'h4000_0000, 4'h1, 2'd2, RESP_SLVERR},
    '{32'h0000_fffc, 8'd5, 32'h5000_0000, 4'hf, 2'd0, RESP_OKAY},
    '{32'h0001_ffff, 8'd2, 32'h6000_0000, 4'h8, 2'd1, RESP_EXOKAY},
    '{32'h0001_0000, 8'd1, 32'h7000_0000, 4'h6, 2'd1, RESP_EXOKAY},
    '{32'h8000_1000, 8'd3, 32'h8000_0000, 4'hf, 2'd2, RESP_SLVERR}
  };

  logic           clk       = 1'b0;
  logic           rstn      = 1'b0;
  addr_t          m_awaddr  = '0;
  logic           m_awvalid = 1'b0;
  logic           m_awready;
  data_t          m_wdata   = '0;
  strb_t          m_wstrb   = '0;
  logic           m_wlast   = 1'b0;
  logic           m_wvalid  = 1'b0;
  logic           m_wready;
  resp_t          m_bresp;
  logic           m_bvalid;
  logic           m_bready  = 1'b0;
  addr_t [NS-1:0] s_awaddr;
  logic  [NS-1:0] s_awvalid;
  logic  [NS-1:0] s_awready = '0;
  data_t [NS-1:0] s_wdata;
  strb_t [NS-1:0] s_wstrb;
  logic  [NS-1:0] s_wlast;
  logic  [NS-1:0] s_wvalid;
  logic  [NS-1:0] s_wready  = '0;
  resp_t [NS-1:0] s_bresp;
  logic  [NS-1:0] s_bvalid  = '0;
  logic  [NS-1:0] s_bready;

  // One log entry per accepted beat as {slave, wlast, wstrb, wdata}
  logic [1:0]  exp_slave = 2'd0;
  logic [38:0] w_log [$];
  int          aw_hits [NS];
  addr_t       aw_seen;
  logic [31:0] lfsr = 32'h89a9_4475;
  int          errors = 0;
  int          tests_failed = 0;
  logic        timed_out = 1'b0;

  axi_write_xbar i_axi_write_xbar (.*);

  assign s_bresp[0] = RESP_OKAY;
  assign s_bresp[1] = RESP_EXOKAY;
  assign s_bresp[2] = RESP_SLVERR;

  initial begin
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected %0h got %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s at %0t", what, $time);
    timed_out = 1'b1;
    errors++;
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: failed", name);
      tests_failed++;
    end
  endtask

  // Slave models with random ready and a fixed response after the last beat
  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      s_awready <= '0;
      s_wready  <= '0;
      s_bvalid  <= '0;
    end else begin
      if (s_awvalid != '0) begin
        check_value("s_awvalid", 3'b001 << exp_slave, s_awvalid);
      end
      if (s_wvalid != '0) begin
        check_value("s_wvalid", 3'b001 << exp_slave, s_wvalid);
      end
      for (int i = 0; i < NS; i++) begin
        if (s_awvalid[i] && s_awready[i]) begin
          aw_hits[i]++;
          aw_seen = s_awaddr[i];
        end
        if (s_wvalid[i] && s_wready[i]) begin
          w_log.push_back({2'(i), s_wlast[i], s_wstrb[i], s_wdata[i]});
          if (s_wlast[i]) begin
            s_bvalid[i] <= 1'b1;
          end
        end
        if (s_bvalid[i] && s_bready[i]) begin
          s_bvalid[i] <= 1'b0;
        end
        lfsr = lfsr_step(lfsr);
        s_wready[i] <= lfsr[0];
        lfsr = lfsr_step(lfsr);
        s_awready[i] <= lfsr[0];
      end
    end
  end

  task automatic check_idle();
    check_value("s_awvalid", 0, s_awvalid);
    check_value("s_wvalid", 0, s_wvalid);
    check_value("m_awready", 0, m_awready);
    check_value("m_wready", 0, m_wready);
    check_value("m_bvalid", 0, m_bvalid);
  endtask

  task automatic offer_addr(input int r);
    m_awaddr  <= rows[r].addr;
    m_awvalid <= 1'b1;
    exp_slave <= rows[r].slave;
    w_log.delete();
    for (int i = 0; i < NS; i++) begin
      aw_hits[i] = 0;
    end
  endtask

  task automatic wait_aw_handshake();
    int n = 0;
    @(posedge clk);
    while (!(m_awvalid && m_awready) && !timed_out) begin
      if (n >= TIMEOUT) begin
        report_timeout("the AW handshake");
      end else begin
        @(posedge clk);
        n++;
      end
    end
    m_awvalid <= 1'b0;
  endtask

  task automatic drive_burst(input int r);
    int n;
    for (int k = 0; k < rows[r].beats && !timed_out; k++) begin
      m_wdata  <= rows[r].data + k;
      m_wstrb  <= rows[r].strb;
      m_wlast  <= (k == rows[r].beats - 1);
      m_wvalid <= 1'b1;
      n = 0;
      @(posedge clk);
      while (!(m_wvalid && m_wready) && !timed_out) begin
        if (n >= TIMEOUT) begin
          report_timeout("a W beat to be accepted");
        end else begin
          @(posedge clk);
          n++;
        end
      end
    end
    m_wvalid <= 1'b0;
    m_wlast  <= 1'b0;
  endtask

  task automatic wait_response(input int r);
    int n = 0;
    @(posedge clk);
    while (!m_bvalid && !timed_out) begin
      if (n >= TIMEOUT) begin
        report_timeout("the write response");
      end else begin
        @(posedge clk);
        n++;
      end
    end
    if (!timed_out) begin
      check_value("m_bresp", rows[r].resp, m_bresp);
    end
  endtask

  task automatic take_response(input int r);
    int n = 0;
    m_bready <= 1'b1;
    @(posedge clk);
    while (!(m_bvalid && m_bready) && !timed_out) begin
      if (n >= TIMEOUT) begin
        report_timeout("the B handshake");
      end else begin
        @(posedge clk);
        n++;
      end
    end
    if (!timed_out) begin
      check_value("s_bready", 3'b001 << rows[r].slave, s_bready);
    end
    m_bready <= 1'b0;
  endtask

  task automatic check_row(input int r);
    logic [38:0] beat;
    check_value("beat count", rows[r].beats, w_log.size());
    foreach (w_log[k]) begin
      beat = w_log[k];
      check_value("beat slave", rows[r].slave, beat[38:37]);
      check_value("s_wlast", k == rows[r].beats - 1, beat[36]);
      check_value("s_wstrb", rows[r].strb, beat[35:32]);
      check_value("s_wdata", data_t'(rows[r].data + k), beat[31:0]);
    end
    for (int i = 0; i < NS; i++) begin
      check_value($sformatf("aw handshakes on slave %0d", i), i == rows[r].slave, aw_hits[i]);
    end
    check_value("s_awaddr", rows[r].addr, aw_seen);
  endtask

  initial begin
    int errors_before;
    errors_before = errors;
    // State is unknown until the first edge applies the reset
    @(posedge clk);
    repeat (9) begin
      @(posedge clk);
      check_idle();
    end
    rstn <= 1'b1;
    @(posedge clk);
    check_idle();
    report_test("reset", errors_before);

    offer_addr(0);
    for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
      errors_before = errors;
      wait_aw_handshake();
      drive_burst(r);
      wait_response(r);
      if (!timed_out) begin
        check_row(r);
        // Next address waits behind the open response
        if (r + 1 < NUM_ROWS) begin
          offer_addr(r + 1);
          repeat (4) begin
            @(posedge clk);
            check_value("m_awready", 0, m_awready);
          end
        end
        take_response(r);
      end
      report_test($sformatf("row %0d to slave %0d", r, rows[r].slave), errors_before);
    end

    $display("tests %0d, failed %0d, errors %0d", NUM_ROWS + 1, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/aw_decoder.sv
`include "axi_params.svh"

module aw_decoder (
  input  logic                            clk,
  input  logic                            rstn,
  input  axi_pkg::addr_t                  m_awaddr,
  input  logic                            m_awvalid,
  output logic                            m_awready,
  output axi_pkg::addr_t                  s_awaddr,
  output logic [`AXI_NUM_SLAVES-1:0]      s_awvalid,
  input  logic [`AXI_NUM_SLAVES-1:0]      s_awready,
  input  logic                            b_done,
  output xbar_pkg::slave_sel_t            route,
  output logic                            route_valid
);
  import xbar_pkg::*;

  aw_state_t  state, state_next;
  slave_sel_t dec_sel;
  slave_sel_t route_q;
  logic       aw_hs;

  // Unmapped addresses fall to slave 2
  always_comb begin
    if ((m_awaddr & `REGION0_MASK) == `REGION0_BASE) begin
      dec_sel = SEL_S0;
    end else if ((m_awaddr & `REGION1_MASK) == `REGION1_BASE) begin
      dec_sel = SEL_S1;
    end else begin
      dec_sel = SEL_S2;
    end
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      state   <= AW_IDLE;
      route_q <= SEL_S0;
    end else begin
      state <= state_next;
      if (state == AW_IDLE && m_awvalid) begin
        route_q <= dec_sel;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      AW_IDLE:   if (m_awvalid) state_next = AW_ADDR;
      AW_ADDR:   if (aw_hs) state_next = AW_WAIT_B;
      AW_WAIT_B: if (b_done) state_next = AW_IDLE;
      default:   state_next = AW_IDLE;
    endcase
  end

  // Strobe and ready pass straight through while the address is offered
  always_comb begin
    s_awvalid = '0;
    m_awready = 1'b0;
    if (state == AW_ADDR) begin
      s_awvalid[route_q] = m_awvalid;
      m_awready          = s_awready[route_q];
    end
  end

  assign aw_hs       = m_awvalid & m_awready;
  assign s_awaddr    = m_awaddr;
  assign route       = route_q;
  assign route_valid = (state == AW_WAIT_B);

  a_awvalid_onehot: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0(s_awvalid));

endmodule

// File: hdl/axi_params.svh
`ifndef AXI_PARAMS_SVH
`define AXI_PARAMS_SVH

// Channel widths
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS (`AXI_DATA_BITS / 8)

// Slaves behind the write path
`define AXI_NUM_SLAVES 3

// Slave 0 window, 64 KiB at the bottom of the map
`define REGION0_BASE 32'h0000_0000
`define REGION0_MASK 32'hffff_0000

// Slave 1 window, next 64 KiB
`define REGION1_BASE 32'h0001_0000
`define REGION1_MASK 32'hffff_0000

`endif

// File: hdl/axi_pkg.sv
`include "axi_params.svh"

package axi_pkg;

  // Address and data payload
  typedef logic [`AXI_ADDR_BITS-1:0] addr_t;
  typedef logic [`AXI_DATA_BITS-1:0] data_t;

  // One enable bit per byte lane
  typedef logic [`AXI_STRB_BITS-1:0] strb_t;

  // Write response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

endpackage

// File: hdl/axi_w_if.sv
interface axi_w_if;
  import axi_pkg::*;

  data_t wdata;
  strb_t wstrb;
  logic  wlast;
  logic  wvalid;
  logic  wready;

  // Side that sends the beat
  modport master (
    output wdata, wstrb, wlast, wvalid,
    input  wready
  );

  // Side that accepts the beat
  modport slave (
    input  wdata, wstrb, wlast, wvalid,
    output wready
  );

endinterface

// File: hdl/axi_write_xbar.sv
`include "axi_params.svh"

module axi_write_xbar (
  input  logic                                 clk,
  input  logic                                 rstn,
  // Master AW
  input  axi_pkg::addr_t                       m_awaddr,
  input  logic                                 m_awvalid,
  output logic                                 m_awready,
  // Master W
  input  axi_pkg::data_t                       m_wdata,
  input  axi_pkg::strb_t                       m_wstrb,
  input  logic                                 m_wlast,
  input  logic                                 m_wvalid,
  output logic                                 m_wready,
  // Master B
  output axi_pkg::resp_t                       m_bresp,
  output logic                                 m_bvalid,
  input  logic                                 m_bready,
  // Slave AW
  output axi_pkg::addr_t [`AXI_NUM_SLAVES-1:0] s_awaddr,
  output logic           [`AXI_NUM_SLAVES-1:0] s_awvalid,
  input  logic           [`AXI_NUM_SLAVES-1:0] s_awready,
  // Slave W
  output axi_pkg::data_t [`AXI_NUM_SLAVES-1:0] s_wdata,
  output axi_pkg::strb_t [`AXI_NUM_SLAVES-1:0] s_wstrb,
  output logic           [`AXI_NUM_SLAVES-1:0] s_wlast,
  output logic           [`AXI_NUM_SLAVES-1:0] s_wvalid,
  input  logic           [`AXI_NUM_SLAVES-1:0] s_wready,
  // Slave B
  input  axi_pkg::resp_t [`AXI_NUM_SLAVES-1:0] s_bresp,
  input  logic           [`AXI_NUM_SLAVES-1:0] s_bvalid,
  output logic           [`AXI_NUM_SLAVES-1:0] s_bready
);
  import axi_pkg::*;
  import xbar_pkg::*;

  addr_t      aw_addr;
  slave_sel_t route;
  logic       route_valid;
  logic       b_done;

  axi_w_if m_w ();
  axi_w_if s_w [`AXI_NUM_SLAVES] ();

  assign m_w.wdata  = m_wdata;
  assign m_w.wstrb  = m_wstrb;
  assign m_w.wlast  = m_wlast;
  assign m_w.wvalid = m_wvalid;
  assign m_wready   = m_w.wready;

  // Slave side W and the shared AW address
  for (genvar i = 0; i < `AXI_NUM_SLAVES; i++) begin : g_slv
    assign s_wdata[i]     = s_w[i].wdata;
    assign s_wstrb[i]     = s_w[i].wstrb;
    assign s_wlast[i]     = s_w[i].wlast;
    assign s_wvalid[i]    = s_w[i].wvalid;
    assign s_w[i].wready  = s_wready[i];
    assign s_awaddr[i]    = aw_addr;
  end

  aw_decoder i_aw_decoder (
    .clk         (clk),
    .rstn        (rstn),
    .m_awaddr    (m_awaddr),
    .m_awvalid   (m_awvalid),
    .m_awready   (m_awready),
    .s_awaddr    (aw_addr),
    .s_awvalid   (s_awvalid),
    .s_awready   (s_awready),
    .b_done      (b_done),
    .route       (route),
    .route_valid (route_valid)
  );

  w_router i_w_router (
    .clk         (clk),
    .rstn        (rstn),
    .mst         (m_w),
    .slv0        (s_w[0]),
    .slv1        (s_w[1]),
    .slv2        (s_w[2]),
    .route       (route),
    .route_valid (route_valid)
  );

  b_mux i_b_mux (
    .route       (route),
    .route_valid (route_valid),
    .s_bresp     (s_bresp),
    .s_bvalid    (s_bvalid),
    .s_bready    (s_bready),
    .m_bresp     (m_bresp),
    .m_bvalid    (m_bvalid),
    .m_bready    (m_bready),
    .b_done      (b_done)
  );

endmodule

// File: hdl/b_mux.sv
`include "axi_params.svh"

module b_mux (
  input  xbar_pkg::slave_sel_t                      route,
  input  logic                                      route_valid,
  input  axi_pkg::resp_t [`AXI_NUM_SLAVES-1:0]      s_bresp,
  input  logic           [`AXI_NUM_SLAVES-1:0]      s_bvalid,
  output logic           [`AXI_NUM_SLAVES-1:0]      s_bready,
  output axi_pkg::resp_t                            m_bresp,
  output logic                                      m_bvalid,
  input  logic                                      m_bready,
  output logic                                      b_done
);
  import axi_pkg::*;

  // Only the routed slave is heard, and only while the write is open
  always_comb begin
    m_bvalid = 1'b0;
    m_bresp  = RESP_OKAY;
    s_bready = '0;
    if (route_valid) begin
      m_bvalid        = s_bvalid[route];
      m_bresp         = s_bresp[route];
      s_bready[route] = m_bready;
    end
  end

  // Master side handshake closes the write and frees the route
  assign b_done = m_bvalid & m_bready;

endmodule

// File: hdl/w_router.sv
module w_router (
  input  logic                 clk,
  input  logic                 rstn,
  axi_w_if.slave               mst,
  axi_w_if.master              slv0,
  axi_w_if.master              slv1,
  axi_w_if.master              slv2,
  input  xbar_pkg::slave_sel_t route,
  input  logic                 route_valid
);
  import axi_pkg::*;
  import xbar_pkg::*;

  data_arb_lock_t lock, lock_next;
  data_arb_lock_t route_lock;
  logic           lock_enter;
  logic [2:0]     lock_oh;
  logic [2:0]     slv_ready;
  logic [2:0]     slv_hs;

  // Beat register
  data_t          wdata_q;
  strb_t          wstrb_q;
  logic           wlast_q;

  always_comb begin
    case (route)
      SEL_S0:  route_lock = LOCK_S0;
      SEL_S1:  route_lock = LOCK_S1;
      default: route_lock = LOCK_S2;
    endcase
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      lock <= LOCK_NO;
    end else begin
      lock <= lock_next;
    end
  end

  // Lock per beat, release on the slave handshake
  always_comb begin
    lock_next = lock;
    case (lock)
      LOCK_NO: begin
        if (route_valid && mst.wvalid) begin
          lock_next = route_lock;
        end
      end
      LOCK_S0, LOCK_S1, LOCK_S2: begin
        if (|slv_hs) begin
          lock_next = LOCK_NO;
        end
      end
      default: lock_next = LOCK_NO;
    endcase
  end

  assign lock_enter = (lock == LOCK_NO) && (lock_next != LOCK_NO);

  always_ff @(posedge clk) begin
    if (lock_enter) begin
      wdata_q <= mst.wdata;
      wstrb_q <= mst.wstrb;
      wlast_q <= mst.wlast;
    end
  end

  assign lock_oh   = {lock == LOCK_S2, lock == LOCK_S1, lock == LOCK_S0};
  assign slv_ready = {slv2.wready, slv1.wready, slv0.wready};
  assign slv_hs    = lock_oh & slv_ready;

  // Master sees the ready of the locked slave only
  assign mst.wready = |slv_hs;

  assign slv0.wvalid = lock_oh[0];
  assign slv0.wdata  = lock_oh[0] ? wdata_q : '0;
  assign slv0.wstrb  = lock_oh[0] ? wstrb_q : '0;
  assign slv0.wlast  = lock_oh[0] & wlast_q;

  assign slv1.wvalid = lock_oh[1];
  assign slv1.wdata  = lock_oh[1] ? wdata_q : '0;
  assign slv1.wstrb  = lock_oh[1] ? wstrb_q : '0;
  assign slv1.wlast  = lock_oh[1] & wlast_q;

  assign slv2.wvalid = lock_oh[2];
  assign slv2.wdata  = lock_oh[2] ? wdata_q : '0;
  assign slv2.wstrb  = lock_oh[2] ? wstrb_q : '0;
  assign slv2.wlast  = lock_oh[2] & wlast_q;

  // Stalled beat keeps its payload and its target
  a_beat_stable: assert property (@(posedge clk) disable iff (!rstn)
    (|lock_oh && !mst.wready) |=>
      ($stable({wdata_q, wstrb_q, wlast_q}) && $stable(lock)));

  a_wvalid_onehot: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({slv2.wvalid, slv1.wvalid, slv0.wvalid}));

endmodule

// File: hdl/xbar_pkg.sv
package xbar_pkg;

  // Slave picked by the address decode
  typedef enum logic [1:0] {
    SEL_S0 = 2'd0,
    SEL_S1 = 2'd1,
    SEL_S2 = 2'd2
  } slave_sel_t;

  // Write data router state, one lock per slave
  typedef enum logic [1:0] {
    LOCK_S0 = 2'd0,
    LOCK_S1 = 2'd1,
    LOCK_S2 = 2'd2,
    LOCK_NO = 2'd3
  } data_arb_lock_t;

  // Address decoder FSM
  typedef enum logic [1:0] {
    AW_IDLE   = 2'd0,
    AW_ADDR   = 2'd1,
    AW_WAIT_B = 2'd2
  } aw_state_t;

endpackage

// File: verilog.f
+incdir+hdl
hdl/axi_pkg.sv
hdl/xbar_pkg.sv
hdl/axi_w_if.sv
hdl/aw_decoder.sv
hdl/w_router.sv
hdl/b_mux.sv
hdl/axi_write_xbar.sv
dv/tb_axi_write_xbar.sv
